//--- rtl/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
) (
    exec_operands_if.sink      operands,
    exec_result_if.branch_side res
);

    localparam logic [XLEN-1:0] STEP = exec_pkg::PC_STEP;

    logic [XLEN-1:0] rel_target;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;

    assign rel_target = operands.pc_plus4 - STEP + operands.imm;
    assign jalr_sum   = operands.rs1_val + operands.imm;

    always_comb
    begin
        case (operands.op)
            exec_pkg::OP_BEQ:  taken = operands.rs1_val == operands.rs2_val;
            exec_pkg::OP_BNE:  taken = operands.rs1_val != operands.rs2_val;
            exec_pkg::OP_BLT:  taken = $signed(operands.rs1_val) < $signed(operands.rs2_val);
            exec_pkg::OP_BGE:  taken = $signed(operands.rs1_val) >= $signed(operands.rs2_val);
            exec_pkg::OP_BLTU: taken = operands.rs1_val < operands.rs2_val;
            exec_pkg::OP_BGEU: taken = operands.rs1_val >= operands.rs2_val;
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (!taken)
            res.target_pc = operands.pc_plus4;
        else if (operands.op == exec_pkg::OP_JALR)
            res.target_pc = {jalr_sum[XLEN-1:1], 1'b0};
        else
            res.target_pc = rel_target;
    end

    assign res.branch_taken = taken;

endmodule

//--- rtl/exec_bus_if.sv
`timescale 1ns/1ps

// Operands after bypass selection, plus the decoded fields that go with them
interface exec_operands_if #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
);
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc_plus4;
    exec_pkg::exec_op_t op;
    logic              use_imm;

    modport source (output rs1_val, rs2_val, imm, pc_plus4, op, use_imm);
    modport sink   (input  rs1_val, rs2_val, imm, pc_plus4, op, use_imm);

endinterface

// Combinational results headed for the stage register
interface exec_result_if #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
);
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target_pc;
    logic            branch_taken;
    logic            write_rd;
    logic            mem_load;

    modport alu_side    (output result, write_rd, mem_load);
    modport branch_side (output target_pc, branch_taken);
    modport sink        (input  result, target_pc, branch_taken, write_rd, mem_load);

endinterface

//--- rtl/exec_pkg.sv
package exec_pkg;

    localparam int DEFAULT_XLEN = 64;

    // Bytes per instruction; pc_plus4 is the PC plus this step
    localparam int PC_STEP = 4;

    typedef logic [4:0] reg_addr_t;

    localparam reg_addr_t ZERO_REG = 5'd0;

    // Immediate forms share the register-form member and set use_imm
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LUI,
        OP_AUIPC,
        OP_LOAD,
        OP_STORE,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU
    } exec_op_t;

endpackage

//--- rtl/exec_stage_reg.sv
`timescale 1ns/1ps

module exec_stage_reg #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                accept,
    input  logic                branch_flush,
    input  logic                syscall_flush,
    exec_result_if.sink         res,
    input  logic [XLEN-1:0]     store_data,
    input  exec_pkg::reg_addr_t rd,
    input  exec_pkg::exec_op_t  op,
    output logic [XLEN-1:0]     result,
    output logic [XLEN-1:0]     store_data_out,
    output logic [XLEN-1:0]     target_pc,
    output exec_pkg::reg_addr_t rd_out,
    output exec_pkg::exec_op_t  op_out,
    output logic                write_rd,
    output logic                branch_taken,
    output logic                mem_load
);

    logic bubble;

    // A syscall flush wins at any edge, a branch flush only when accepting
    assign bubble = reset || syscall_flush || (accept && branch_flush);

    always_ff @(posedge clk)
    begin
        if (bubble)
        begin
            result         <= '0;
            store_data_out <= '0;
            target_pc      <= '0;
            rd_out         <= exec_pkg::ZERO_REG;
            op_out         <= exec_pkg::OP_NOP;
            write_rd       <= 1'b0;
            branch_taken   <= 1'b0;
            mem_load       <= 1'b0;
        end
        else if (accept)
        begin
            result         <= res.result;
            store_data_out <= store_data;
            target_pc      <= res.target_pc;
            rd_out         <= rd;
            op_out         <= op;
            write_rd       <= res.write_rd;
            branch_taken   <= res.branch_taken;
            mem_load       <= res.mem_load;
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_enable,
    input  logic [XLEN-1:0]     rs1_val,
    input  logic [XLEN-1:0]     rs2_val,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc_plus4,
    input  exec_pkg::exec_op_t  op,
    input  logic                use_imm,
    input  exec_pkg::reg_addr_t rs1,
    input  exec_pkg::reg_addr_t rs2,
    input  exec_pkg::reg_addr_t rd,
    // Older instruction now held in the stage register
    input  exec_pkg::reg_addr_t alu_rd,
    input  logic [XLEN-1:0]     alu_result_fwd,
    input  logic                alu_is_load,
    input  exec_pkg::reg_addr_t mm_rd,
    input  logic [XLEN-1:0]     mm_result_fwd,
    input  logic                mm_is_load,
    input  logic [XLEN-1:0]     mm_load_data,
    input  exec_pkg::reg_addr_t wb_rd,
    input  logic [XLEN-1:0]     wb_data,
    input  logic                branch_flush,
    input  logic                syscall_flush,
    output logic [XLEN-1:0]     result,
    output logic [XLEN-1:0]     store_data,
    output exec_pkg::reg_addr_t rd_out,
    output exec_pkg::exec_op_t  op_out,
    output logic [XLEN-1:0]     target_pc,
    output logic                write_rd,
    output logic                branch_taken,
    output logic                mem_load,
    output logic                ready
);

    logic            accept;
    logic [XLEN-1:0] fwd_store_data;

    exec_operands_if #(.XLEN(XLEN)) operands_bus ();
    exec_result_if   #(.XLEN(XLEN)) result_bus ();

    assign accept = in_enable && ready;

    operand_forward #(.XLEN(XLEN)) u_forward (
        .rs1(rs1), .rs2(rs2), .alu_rd(alu_rd), .mm_rd(mm_rd), .wb_rd(wb_rd),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .pc_plus4(pc_plus4),
        .alu_result_fwd(alu_result_fwd), .mm_result_fwd(mm_result_fwd),
        .mm_load_data(mm_load_data), .wb_data(wb_data),
        .alu_is_load(alu_is_load), .mm_is_load(mm_is_load), .op(op), .use_imm(use_imm),
        .ready(ready), .store_data(fwd_store_data), .operands(operands_bus.source)
    );

    int_alu #(.XLEN(XLEN)) u_alu (
        .operands(operands_bus.sink),
        .res(result_bus.alu_side)
    );

    branch_resolve #(.XLEN(XLEN)) u_branch (
        .operands(operands_bus.sink),
        .res(result_bus.branch_side)
    );

    exec_stage_reg #(.XLEN(XLEN)) u_stage_reg (
        .clk(clk), .reset(reset), .accept(accept),
        .branch_flush(branch_flush), .syscall_flush(syscall_flush),
        .res(result_bus.sink), .store_data(fwd_store_data), .rd(rd), .op(op),
        .result(result), .store_data_out(store_data), .target_pc(target_pc),
        .rd_out(rd_out), .op_out(op_out), .write_rd(write_rd),
        .branch_taken(branch_taken), .mem_load(mem_load)
    );

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
) (
    exec_operands_if.sink   operands,
    exec_result_if.alu_side res
);

    localparam int SHAMT_W = $clog2(XLEN);
    localparam logic [XLEN-1:0] STEP = exec_pkg::PC_STEP;

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    pc;

    assign op_a  = operands.rs1_val;
    assign op_b  = operands.use_imm ? operands.imm : operands.rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];
    // PC of the instruction itself
    assign pc    = operands.pc_plus4 - STEP;

    always_comb
    begin
        res.result   = '0;
        res.write_rd = 1'b1;
        res.mem_load = 1'b0;
        case (operands.op)
            exec_pkg::OP_ADD:   res.result = op_a + op_b;
            exec_pkg::OP_SUB:   res.result = op_a - op_b;
            exec_pkg::OP_SLL:   res.result = op_a << shamt;
            exec_pkg::OP_SRL:   res.result = op_a >> shamt;
            exec_pkg::OP_SRA:   res.result = $signed(op_a) >>> shamt;
            exec_pkg::OP_SLT:   res.result[0] = $signed(op_a) < $signed(op_b);
            exec_pkg::OP_SLTU:  res.result[0] = op_a < op_b;
            exec_pkg::OP_XOR:   res.result = op_a ^ op_b;
            exec_pkg::OP_OR:    res.result = op_a | op_b;
            exec_pkg::OP_AND:   res.result = op_a & op_b;
            exec_pkg::OP_LUI:   res.result = operands.imm;
            exec_pkg::OP_AUIPC: res.result = pc + operands.imm;
            exec_pkg::OP_LOAD:
            begin
                res.result   = op_a + operands.imm;
                res.mem_load = 1'b1;
            end
            exec_pkg::OP_STORE:
            begin
                res.result   = op_a + operands.imm;
                res.write_rd = 1'b0;
            end
            // Link value
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR:  res.result = operands.pc_plus4;
            // Branches and bubbles write nothing
            default:            res.write_rd = 1'b0;
        endcase
    end

endmodule

//--- rtl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward #(
    parameter int XLEN = exec_pkg::DEFAULT_XLEN
) (
    input  exec_pkg::reg_addr_t rs1,
    input  exec_pkg::reg_addr_t rs2,
    input  exec_pkg::reg_addr_t alu_rd,
    input  exec_pkg::reg_addr_t mm_rd,
    input  exec_pkg::reg_addr_t wb_rd,
    input  logic [XLEN-1:0]     rs1_val,
    input  logic [XLEN-1:0]     rs2_val,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc_plus4,
    input  logic [XLEN-1:0]     alu_result_fwd,
    input  logic [XLEN-1:0]     mm_result_fwd,
    input  logic [XLEN-1:0]     mm_load_data,
    input  logic [XLEN-1:0]     wb_data,
    input  logic                alu_is_load,
    input  logic                mm_is_load,
    input  exec_pkg::exec_op_t  op,
    input  logic                use_imm,
    output logic                ready,
    output logic [XLEN-1:0]     store_data,
    exec_operands_if.source     operands
);

    logic [XLEN-1:0] mm_value;
    logic [XLEN-1:0] fwd_rs1;
    logic [XLEN-1:0] fwd_rs2;

    // Youngest producer wins and x0 is never bypassed
    function automatic logic [XLEN-1:0] pick_operand(
        input exec_pkg::reg_addr_t src,
        input logic [XLEN-1:0]     rf_val
    );
        logic [XLEN-1:0] val;
        val = rf_val;
        if (src != exec_pkg::ZERO_REG)
        begin
            if (src == alu_rd)
                val = alu_result_fwd;
            else if (src == mm_rd)
                val = mm_value;
            else if (src == wb_rd)
                val = wb_data;
        end
        return val;
    endfunction

    assign mm_value = mm_is_load ? mm_load_data : mm_result_fwd;

    always_comb
    begin
        fwd_rs1 = pick_operand(rs1, rs1_val);
        fwd_rs2 = pick_operand(rs2, rs2_val);
    end

    // Load data is not back yet when the load sits in the ALU stage
    assign ready = !(alu_is_load && (alu_rd != exec_pkg::ZERO_REG) &&
                     ((rs1 == alu_rd) || (rs2 == alu_rd)));

    assign operands.rs1_val  = fwd_rs1;
    assign operands.rs2_val  = fwd_rs2;
    assign operands.imm      = imm;
    assign operands.pc_plus4 = pc_plus4;
    assign operands.op       = op;
    assign operands.use_imm  = use_imm;
    assign store_data        = fwd_rs2;

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_execute_stage -f sources.f -o sim_exec

./obj_dir/sim_exec +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- sources.f
rtl/exec_pkg.sv
rtl/exec_bus_if.sv
rtl/operand_forward.sv
rtl/int_alu.sv
rtl/branch_resolve.sv
rtl/exec_stage_reg.sv
rtl/execute_stage.sv
testbench/execute_stage_assert.sv
testbench/tb_execute_stage.sv

//--- testbench/execute_stage_assert.sv
`timescale 1ns/1ps

module execute_stage_assert #(
    parameter int XLEN = 64
) (
    input logic                clk,
    input logic                reset,
    input logic                in_enable,
    input logic [XLEN-1:0]     rs1_val,
    input logic [XLEN-1:0]     rs2_val,
    input logic [XLEN-1:0]     imm,
    input logic [XLEN-1:0]     pc_plus4,
    input exec_pkg::exec_op_t  op,
    input logic                use_imm,
    input exec_pkg::reg_addr_t rs1,
    input exec_pkg::reg_addr_t rs2,
    input exec_pkg::reg_addr_t rd,
    input exec_pkg::reg_addr_t alu_rd,
    input logic [XLEN-1:0]     alu_result_fwd,
    input logic                alu_is_load,
    input exec_pkg::reg_addr_t mm_rd,
    input logic [XLEN-1:0]     mm_result_fwd,
    input logic                mm_is_load,
    input logic [XLEN-1:0]     mm_load_data,
    input exec_pkg::reg_addr_t wb_rd,
    input logic [XLEN-1:0]     wb_data,
    input logic                branch_flush,
    input logic                syscall_flush,
    input logic [XLEN-1:0]     result,
    input logic [XLEN-1:0]     store_data,
    input exec_pkg::reg_addr_t rd_out,
    input exec_pkg::exec_op_t  op_out,
    input logic [XLEN-1:0]     target_pc,
    input logic                write_rd,
    input logic                branch_taken,
    input logic                mem_load,
    input logic                ready
);

    logic            failed = 1'b0;
    string           fail_name;
    logic [63:0]     fail_got;
    logic [63:0]     fail_exp;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] s2;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] e_res;
    logic [XLEN-1:0] e_tgt;
    logic            e_wr;
    logic            e_tk;
    logic            exp_ready;
    logic            acc;
    logic [XLEN-1:0] m_res;
    logic [XLEN-1:0] m_store;
    logic [XLEN-1:0] m_tgt;
    logic [4:0]      m_rd;
    logic [4:0]      m_op;
    logic            m_wr;
    logic            m_tk;
    logic            m_load;

    function automatic logic [XLEN-1:0] bypass(input logic [4:0] src, input logic [XLEN-1:0] rf);
        if (src == 5'd0)
            return rf;
        if (src == alu_rd)
            return alu_result_fwd;
        if (src == mm_rd)
            return mm_is_load ? mm_load_data : mm_result_fwd;
        if (src == wb_rd)
            return wb_data;
        return rf;
    endfunction

    task automatic record(input string name, input logic [63:0] got, input logic [63:0] exp);
        failed    = 1'b1;
        fail_name = name;
        fail_got  = got;
        fail_exp  = exp;
        $error("%s got %h expected %h", name, got, exp);
    endtask

    always_comb
    begin
        a         = bypass(rs1, rs1_val);
        s2        = bypass(rs2, rs2_val);
        b         = use_imm ? imm : s2;
        pc        = pc_plus4 - 4;
        exp_ready = !(alu_is_load && alu_rd != 5'd0 && (rs1 == alu_rd || rs2 == alu_rd));
        acc       = in_enable && ready;
        e_wr      = 1'b1;
        e_tk      = 1'b0;
        e_res     = '0;
        case (op)
            exec_pkg::OP_ADD:   e_res = a + b;
            exec_pkg::OP_SUB:   e_res = a - b;
            exec_pkg::OP_SLL:   e_res = a << b[$clog2(XLEN)-1:0];
            exec_pkg::OP_SRL:   e_res = a >> b[$clog2(XLEN)-1:0];
            exec_pkg::OP_SRA:   e_res = $signed(a) >>> b[$clog2(XLEN)-1:0];
            exec_pkg::OP_SLT:   e_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            exec_pkg::OP_SLTU:  e_res = {{(XLEN-1){1'b0}}, a < b};
            exec_pkg::OP_XOR:   e_res = a ^ b;
            exec_pkg::OP_OR:    e_res = a | b;
            exec_pkg::OP_AND:   e_res = a & b;
            exec_pkg::OP_LUI:   e_res = imm;
            exec_pkg::OP_AUIPC: e_res = pc + imm;
            exec_pkg::OP_LOAD:  e_res = a + imm;
            exec_pkg::OP_STORE:
            begin
                e_res = a + imm;
                e_wr  = 1'b0;
            end
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR:
            begin
                e_res = pc_plus4;
                e_tk  = 1'b1;
            end
            exec_pkg::OP_BEQ:   {e_wr, e_tk} = {1'b0, a == s2};
            exec_pkg::OP_BNE:   {e_wr, e_tk} = {1'b0, a != s2};
            exec_pkg::OP_BLT:   {e_wr, e_tk} = {1'b0, $signed(a) < $signed(s2)};
            exec_pkg::OP_BGE:   {e_wr, e_tk} = {1'b0, $signed(a) >= $signed(s2)};
            exec_pkg::OP_BLTU:  {e_wr, e_tk} = {1'b0, a < s2};
            exec_pkg::OP_BGEU:  {e_wr, e_tk} = {1'b0, a >= s2};
            default:            e_wr = 1'b0;
        endcase
        if (!e_tk)
            e_tgt = pc_plus4;
        else if (op == exec_pkg::OP_JALR)
            e_tgt = (a + imm) & ~{{(XLEN-1){1'b0}}, 1'b1};
        else
            e_tgt = pc + imm;
    end

    // Reference copy of the stage register
    always_ff @(posedge clk)
    begin
        if (reset || syscall_flush || (acc && branch_flush))
            {m_res, m_store, m_tgt, m_rd, m_op, m_wr, m_tk, m_load} <= '0;
        else if (acc)
        begin
            m_res   <= e_res;
            m_store <= s2;
            m_tgt   <= e_tgt;
            m_rd    <= rd;
            m_op    <= op;
            m_wr    <= e_wr;
            m_tk    <= e_tk;
            m_load  <= (op == exec_pkg::OP_LOAD);
        end
    end

    a_reset: assert property (@(posedge clk) $fell(reset) |->
        !write_rd && !branch_taken && !mem_load && op_out == exec_pkg::OP_NOP)
        else record("op_out", 64'(op_out), 0);
    a_ready: assert property (@(posedge clk) disable iff (reset) ready == exp_ready)
        else record("ready", 64'(ready), 64'(exp_ready));
    a_hold: assert property (@(posedge clk) disable iff (reset) (!ready && !syscall_flush) |=>
        $stable(result) && $stable(target_pc) && $stable(op_out) && $stable(rd_out))
        else record("result", result, $past(result));
    a_bubble: assert property (@(posedge clk) disable iff (reset)
        (syscall_flush || (acc && branch_flush)) |=>
        result == 0 && target_pc == 0 && store_data == 0 && op_out == exec_pkg::OP_NOP)
        else record("op_out", 64'(op_out), 0);
    a_result: assert property (@(posedge clk) disable iff (reset) result == m_res)
        else record("result", result, m_res);
    a_store: assert property (@(posedge clk) disable iff (reset) store_data == m_store)
        else record("store_data", store_data, m_store);
    a_target: assert property (@(posedge clk) disable iff (reset) target_pc == m_tgt)
        else record("target_pc", target_pc, m_tgt);
    a_rd: assert property (@(posedge clk) disable iff (reset) rd_out == m_rd)
        else record("rd_out", 64'(rd_out), 64'(m_rd));
    a_op: assert property (@(posedge clk) disable iff (reset) op_out == m_op)
        else record("op_out", 64'(op_out), 64'(m_op));
    a_flags: assert property (@(posedge clk) disable iff (reset)
        {write_rd, branch_taken, mem_load} == {m_wr, m_tk, m_load})
        else record("flags", 64'({write_rd, branch_taken, mem_load}),
                    64'({m_wr, m_tk, m_load}));

endmodule

bind execute_stage execute_stage_assert #(.XLEN(XLEN)) u_check (.*);

//--- testbench/tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage;

    localparam int XLEN       = 64;
    localparam int RAND_COUNT = 300;
    localparam int DIRECTED   = 60;

    logic clk = 1'b0;
    logic reset, in_enable, use_imm, alu_is_load, mm_is_load, branch_flush, syscall_flush;
    logic [XLEN-1:0] rs1_val, rs2_val, imm, pc_plus4, alu_result_fwd;
    logic [XLEN-1:0] mm_result_fwd, mm_load_data, wb_data;
    exec_pkg::exec_op_t op;
    exec_pkg::reg_addr_t rs1, rs2, rd, alu_rd, mm_rd, wb_rd;
    logic [XLEN-1:0] result, store_data, target_pc;
    exec_pkg::reg_addr_t rd_out;
    exec_pkg::exec_op_t op_out;
    logic write_rd, branch_taken, mem_load, ready;

    execute_stage #(.XLEN(XLEN)) UUT (.*);

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // New instruction with fresh random values and register numbers up to reg_max
    task automatic drive(input int op_sel, input logic imm_form, input int reg_max);
        @(negedge clk);
        in_enable = 1'b1;
        op = exec_pkg::exec_op_t'(op_sel);
        use_imm = imm_form;
        {rs1_val, rs2_val, imm} = {rand_word(), rand_word(), rand_word()};
        pc_plus4 = {rand_word()} & ~64'h3;
        {alu_result_fwd, mm_result_fwd, mm_load_data, wb_data} =
            {rand_word(), rand_word(), rand_word(), rand_word()};
        rs1 = exec_pkg::reg_addr_t'($urandom_range(0, reg_max));
        rs2 = exec_pkg::reg_addr_t'($urandom_range(0, reg_max));
        rd = exec_pkg::reg_addr_t'($urandom_range(0, 31));
        alu_rd = exec_pkg::reg_addr_t'($urandom_range(0, reg_max));
        mm_rd = exec_pkg::reg_addr_t'($urandom_range(0, reg_max));
        wb_rd = exec_pkg::reg_addr_t'($urandom_range(0, reg_max));
        {alu_is_load, mm_is_load} = 2'b00;
        {branch_flush, syscall_flush} = 2'b00;
    endtask

    always @(posedge clk)
    begin
        if (UUT.u_check.failed)
        begin
            $display("FAILED %s got %h expected %h", UUT.u_check.fail_name,
                     UUT.u_check.fail_got, UUT.u_check.fail_exp);
            stop_with_failure();
        end
    end

    initial
    begin
        #((RAND_COUNT + DIRECTED + 20) * 40);
        $display("Timeout: the run did not finish in its time budget");
        stop_with_failure();
    end

    initial
    begin
        void'($urandom(1183));
        reset = 1'b1;
        {in_enable, use_imm, alu_is_load, mm_is_load, branch_flush, syscall_flush} = '0;
        {rs1_val, rs2_val, imm, pc_plus4} = '0;
        {alu_result_fwd, mm_result_fwd, mm_load_data, wb_data} = '0;
        op = exec_pkg::OP_NOP;
        {rs1, rs2, rd, alu_rd, mm_rd, wb_rd} = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // Every opcode in both forms with operands mostly from the register file
        for (int i = 0; i <= 22; i++)
        begin
            drive(i, 1'b0, 31);
            drive(i, 1'b1, 31);
        end
        // Priority among matching stages, then load data and x0
        drive(1, 1'b0, 0);
        {rs1, rs2, alu_rd, mm_rd, wb_rd} = {5'd3, 5'd3, 5'd3, 5'd3, 5'd3};
        drive(1, 1'b0, 0);
        {rs1, rs2, mm_rd, wb_rd, mm_is_load} = {5'd3, 5'd4, 5'd3, 5'd4, 1'b1};
        drive(17, 1'b0, 0);
        {rs1, rs2, wb_rd} = {5'd5, 5'd5, 5'd5};
        // Load-use stall held for two cycles
        drive(1, 1'b0, 0);
        {rs1, alu_rd, alu_is_load} = {5'd2, 5'd2, 1'b1};
        @(negedge clk);
        drive(15, 1'b0, 0);
        syscall_flush = 1'b1;
        drive(16, 1'b0, 0);
        branch_flush = 1'b1;
        drive(1, 1'b0, 0);
        for (int i = 0; i < RAND_COUNT; i++)
        begin
            drive($urandom_range(0, 22), 1'($urandom_range(0, 1)), 3);
            {alu_is_load, mm_is_load} = 2'($urandom_range(0, 3));
            branch_flush = ($urandom_range(0, 15) == 0);
            syscall_flush = ($urandom_range(0, 15) == 0);
            in_enable = ($urandom_range(0, 7) != 0);
        end
        repeat (3) @(negedge clk);
        if (!UUT.u_check.failed)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("FAILED %s got %h expected %h", UUT.u_check.fail_name,
                     UUT.u_check.fail_got, UUT.u_check.fail_exp);
            stop_with_failure();
        end
    end

endmodule
